// File: rtl/llc_defs.svh
`ifndef LLC_DEFS_SVH
`define LLC_DEFS_SVH

`default_nettype none

// cache geometry, 4 ways by 16 sets
`define LLC_WAYS     4
`define LLC_INDEX_W  4
`define LLC_TAG_W    8
// byte plus block offset inside a line
`define LLC_OFFSET_W 4
// descriptor id and miss counter widths
`define LLC_ID_W     2
`define LLC_CNT_W    3
`define LLC_ADDR_W   (`LLC_OFFSET_W + `LLC_INDEX_W + `LLC_TAG_W)

`default_nettype wire

`endif

// File: rtl/llc_addr_pkg.sv
`include "llc_defs.svh"

`default_nettype none

// address side of the cache: splitting an address into its fields
package llc_addr_pkg;

  // full byte address
  typedef logic [`LLC_ADDR_W-1:0]  addr_t;
  // set index
  typedef logic [`LLC_INDEX_W-1:0] index_t;
  // tag stored per line
  typedef logic [`LLC_TAG_W-1:0]   tag_t;
  // one-hot way indicator
  typedef logic [`LLC_WAYS-1:0]    way_t;

  // field positions inside addr_t
  // layout is {tag, index, offset}
  localparam int unsigned INDEX_BASE = `LLC_OFFSET_W;
  localparam int unsigned TAG_BASE   = `LLC_OFFSET_W + `LLC_INDEX_W;

endpackage

`default_nettype wire

// File: rtl/llc_desc_pkg.sv
`include "llc_defs.svh"

`default_nettype none

// descriptor side of the cache: what travels through the hit/miss stage
package llc_desc_pkg;
  import llc_addr_pkg::*;

  // transaction id
  typedef logic [`LLC_ID_W-1:0]  id_t;
  // outstanding misses of one id
  typedef logic [`LLC_CNT_W-1:0] cnt_t;

  // annotated descriptor as it leaves the stage
  typedef struct packed {
    addr_t addr;       // request address
    id_t   id;         // transaction id
    logic  rw;         // 0 read, 1 write
    way_t  way;        // way the descriptor operates on
    logic  refill;     // line must be fetched from memory
    logic  evict;      // dirty victim must be written back
    tag_t  evict_tag;  // tag of the victim line
  } desc_t;

endpackage

`default_nettype wire

// File: rtl/llc_tag_if.sv
`timescale 1ns/1ps

`default_nettype none

// lookup channel between the control module and the tag store
interface llc_tag_if
  import llc_addr_pkg::*;
();

  // request, lookup plus allocation in one step
  logic   req_valid;
  logic   req_ready;
  index_t req_index;
  tag_t   req_tag;
  logic   req_dirty;

  // response, held by the store until res_ack
  logic   res_valid;
  logic   res_hit;
  way_t   res_way;
  logic   res_evict;
  tag_t   res_evict_tag;
  logic   res_ack;

  modport ctrl (
    output req_valid, req_index, req_tag, req_dirty, res_ack,
    input  req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

  modport store (
    input  req_valid, req_index, req_tag, req_dirty, res_ack,
    output req_ready, res_valid, res_hit, res_way, res_evict, res_evict_tag
  );

endinterface

`default_nettype wire

// File: rtl/llc_hit_miss_ctrl.sv
`include "llc_defs.svh"

`timescale 1ns/1ps

`default_nettype none

module llc_hit_miss_ctrl
  import llc_addr_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  // descriptor input
  input  logic   desc_valid_i,
  output logic   desc_ready_o,
  input  addr_t  desc_addr_i,
  input  id_t    desc_id_i,
  input  logic   desc_rw_i,
  // hit and miss ports share the out_ fields
  output logic   hit_valid_o,
  input  logic   hit_ready_i,
  output logic   miss_valid_o,
  input  logic   miss_ready_i,
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output logic   out_rw_o,
  output way_t   out_way_o,
  output logic   out_refill_o,
  output logic   out_evict_o,
  output tag_t   out_evict_tag_o,
  // tag store
  llc_tag_if.ctrl tag,
  input  logic   init_done_i,
  // lock box
  output logic   lock_req_o,
  output index_t lock_index_o,
  output way_t   lock_way_o,
  input  logic   locked_i,
  // miss counters
  output logic   cnt_up_o,
  output id_t    cnt_up_id_o,
  input  logic   to_miss_i,
  input  logic   stall_i
);

  logic  busy_q;          // a descriptor sits in the unit
  addr_t addr_q;
  id_t   id_q;
  logic  rw_q;
  logic  to_miss_hold_q;  // keeps the miss route once offered
  logic  can_accept;
  logic  accept;
  logic  go;
  logic  to_hit;
  logic  out_xfer;
  desc_t out_desc;

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  // free, or freed by a transfer in this very cycle
  assign can_accept   = init_done_i & (~busy_q | out_xfer);
  assign desc_ready_o = can_accept & tag.req_ready;
  assign accept       = desc_valid_i & desc_ready_o;

  // lookup goes to the store straight from the input fields
  assign tag.req_valid = desc_valid_i & can_accept;
  assign tag.req_index = desc_addr_i[INDEX_BASE +: `LLC_INDEX_W];
  assign tag.req_tag   = desc_addr_i[TAG_BASE +: `LLC_TAG_W];
  // writes leave the line dirty
  assign tag.req_dirty = desc_rw_i;

  ////////////////////////////////////////////////////////////
  // routing
  ////////////////////////////////////////////////////////////

  // offer only with a response and a free, unstalled line
  assign go     = busy_q & tag.res_valid & ~locked_i & ~stall_i;
  // a hit bypasses only if the id has nothing in the miss path
  assign to_hit = tag.res_hit & ~(to_miss_i | to_miss_hold_q);

  assign hit_valid_o  = go & to_hit;
  assign miss_valid_o = go & ~to_hit;
  assign out_xfer     = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);
  assign tag.res_ack  = out_xfer;

  // outgoing descriptor, hits never refill or evict
  always_comb begin
    out_desc.addr      = addr_q;
    out_desc.id        = id_q;
    out_desc.rw        = rw_q;
    out_desc.way       = tag.res_way;
    out_desc.refill    = ~tag.res_hit;
    out_desc.evict     = ~tag.res_hit & tag.res_evict;
    out_desc.evict_tag = tag.res_evict_tag;
  end

  assign out_addr_o      = out_desc.addr;
  assign out_id_o        = out_desc.id;
  assign out_rw_o        = out_desc.rw;
  assign out_way_o       = out_desc.way;
  assign out_refill_o    = out_desc.refill;
  assign out_evict_o     = out_desc.evict;
  assign out_evict_tag_o = out_desc.evict_tag;

  // lock the line on any transfer, line is also the lock query
  assign lock_req_o   = out_xfer;
  assign lock_index_o = addr_q[INDEX_BASE +: `LLC_INDEX_W];
  assign lock_way_o   = tag.res_way;
  // count up on miss-port transfers, id is also the counter query
  assign cnt_up_o     = miss_valid_o & miss_ready_i;
  assign cnt_up_id_o  = id_q;

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q         <= 1'b0;
      to_miss_hold_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (out_xfer) begin
        busy_q <= 1'b0;
      end
      // a count-down must not move an offered descriptor to the hit port
      if (out_xfer) begin
        to_miss_hold_q <= 1'b0;
      end else if (miss_valid_o) begin
        to_miss_hold_q <= 1'b1;
      end
    end
  end

  // descriptor fields, loaded on accept only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= desc_addr_i;
      id_q   <= desc_id_i;
      rw_q   <= desc_rw_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/llc_tag_store.sv
`include "llc_defs.svh"

`timescale 1ns/1ps

`default_nettype none

module llc_tag_store
  import llc_addr_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  llc_tag_if.store  tag,
  output logic      init_done_o
);

  localparam int unsigned SETS     = 1 << `LLC_INDEX_W;
  localparam int unsigned WAY_BITS = $clog2(`LLC_WAYS);

  // line state per set and way
  tag_t                tag_q   [SETS][`LLC_WAYS];
  way_t                valid_q [SETS];
  way_t                dirty_q [SETS];
  // round-robin victim per set
  logic [WAY_BITS-1:0] rr_q    [SETS];
  // post-reset clear, one set per cycle
  index_t              clr_cnt_q;
  logic                init_done_q;

  logic                req_xfer;
  way_t                hit_vec;
  logic                hit;
  logic                any_inv;
  logic [WAY_BITS-1:0] hit_idx;
  logic [WAY_BITS-1:0] inv_idx;
  logic [WAY_BITS-1:0] sel_idx;

  assign init_done_o   = init_done_q;
  // blocked while a response waits, unless it is acked now
  assign tag.req_ready = init_done_q & (~tag.res_valid | tag.res_ack);
  assign req_xfer      = tag.req_valid & tag.req_ready;

  ////////////////////////////////////////////////////////////
  // lookup and victim choice
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit_idx = '0;
    inv_idx = '0;
    any_inv = 1'b0;
    // walk downwards so the lowest way wins
    for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = valid_q[tag.req_index][w] && (tag_q[tag.req_index][w] == tag.req_tag);
      if (hit_vec[w]) begin
        hit_idx = WAY_BITS'(w);
      end
      if (!valid_q[tag.req_index][w]) begin
        inv_idx = WAY_BITS'(w);
        any_inv = 1'b1;
      end
    end
    hit = |hit_vec;
    // hit way, else lowest free way, else round-robin victim
    sel_idx = hit ? hit_idx : (any_inv ? inv_idx : rr_q[tag.req_index]);
  end

  ////////////////////////////////////////////////////////////
  // control state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clr_cnt_q     <= '0;
      init_done_q   <= 1'b0;
      tag.res_valid <= 1'b0;
      for (int s = 0; s < SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else begin
      if (!init_done_q) begin
        clr_cnt_q <= clr_cnt_q + 1'b1;
        // last set cleared in this cycle
        if (clr_cnt_q == index_t'(SETS - 1)) begin
          init_done_q <= 1'b1;
        end
      end
      if (req_xfer) begin
        tag.res_valid <= 1'b1;
      end else if (tag.res_ack) begin
        tag.res_valid <= 1'b0;
      end
      // step the pointer only when a valid line is replaced
      if (req_xfer && !hit && !any_inv) begin
        rr_q[tag.req_index] <= rr_q[tag.req_index] + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // arrays and response payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      valid_q[clr_cnt_q] <= '0;
      dirty_q[clr_cnt_q] <= '0;
    end else if (req_xfer) begin
      // allocate together with the lookup
      tag_q[tag.req_index][sel_idx]   <= tag.req_tag;
      valid_q[tag.req_index][sel_idx] <= 1'b1;
      dirty_q[tag.req_index][sel_idx] <= (hit & dirty_q[tag.req_index][sel_idx]) |
                                         tag.req_dirty;
    end
    if (req_xfer) begin
      tag.res_hit       <= hit;
      tag.res_way       <= way_t'(1) << sel_idx;
      tag.res_evict     <= ~hit & ~any_inv & dirty_q[tag.req_index][sel_idx];
      tag.res_evict_tag <= tag_q[tag.req_index][sel_idx];
    end
  end

endmodule

`default_nettype wire

// File: rtl/llc_lock_box.sv
`include "llc_defs.svh"

`timescale 1ns/1ps

`default_nettype none

module llc_lock_box
  import llc_addr_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  // lock request, index and way double as the query
  input  logic   lock_req_i,
  input  index_t lock_index_i,
  input  way_t   lock_way_i,
  output logic   locked_o,
  // single-cycle unlock strobe
  input  logic   unlock_valid_i,
  input  index_t unlock_index_i,
  input  way_t   unlock_way_i
);

  localparam int unsigned SETS = 1 << `LLC_INDEX_W;

  // one lock bit per set and way
  way_t lock_q   [SETS];
  way_t set_mask [SETS];
  way_t clr_mask [SETS];

  always_comb begin
    for (int s = 0; s < SETS; s++) begin
      set_mask[s] = (lock_req_i && lock_index_i == index_t'(s)) ? lock_way_i : '0;
      clr_mask[s] = (unlock_valid_i && unlock_index_i == index_t'(s)) ? unlock_way_i : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      // a new lock wins over an unlock of the same line
      for (int s = 0; s < SETS; s++) begin
        lock_q[s] <= (lock_q[s] & ~clr_mask[s]) | set_mask[s];
      end
    end
  end

  assign locked_o = |(lock_q[lock_index_i] & lock_way_i);

endmodule

`default_nettype wire

// File: rtl/llc_miss_counters.sv
`include "llc_defs.svh"

`timescale 1ns/1ps

`default_nettype none

module llc_miss_counters
  import llc_desc_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic cnt_up_i,
  input  id_t  cnt_up_id_i,
  input  logic cnt_down_i,
  input  id_t  cnt_down_id_i,
  // id of the descriptor in the unit
  input  id_t  query_id_i,
  output logic to_miss_o,
  output logic stall_o
);

  localparam int unsigned IDS     = 1 << `LLC_ID_W;
  localparam cnt_t        CNT_MAX = '1;

  cnt_t            cnt_q   [IDS];
  logic [IDS-1:0]  up_hit;
  logic [IDS-1:0]  down_hit;

  always_comb begin
    for (int i = 0; i < IDS; i++) begin
      up_hit[i]   = cnt_up_i && (cnt_up_id_i == id_t'(i));
      down_hit[i] = cnt_down_i && (cnt_down_id_i == id_t'(i));
    end
  end

  // saturating in both directions, up and down together cancel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < IDS; i++) begin
        if (up_hit[i] && !down_hit[i] && cnt_q[i] != CNT_MAX) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_hit[i] && !up_hit[i] && cnt_q[i] != '0) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  assign to_miss_o = (cnt_q[query_id_i] != '0);
  assign stall_o   = (cnt_q[query_id_i] == CNT_MAX);

endmodule

`default_nettype wire

// File: rtl/llc_hit_miss.sv
`timescale 1ns/1ps

`default_nettype none

module llc_hit_miss
  import llc_addr_pkg::*;
  import llc_desc_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  // descriptor input
  input  logic   desc_valid_i,
  output logic   desc_ready_o,
  input  addr_t  desc_addr_i,
  input  id_t    desc_id_i,
  input  logic   desc_rw_i,
  // hit and miss ports
  output logic   hit_valid_o,
  input  logic   hit_ready_i,
  output logic   miss_valid_o,
  input  logic   miss_ready_i,
  output addr_t  out_addr_o,
  output id_t    out_id_o,
  output logic   out_rw_o,
  output way_t   out_way_o,
  output logic   out_refill_o,
  output logic   out_evict_o,
  output tag_t   out_evict_tag_o,
  // strobes from downstream
  input  logic   unlock_valid_i,
  input  index_t unlock_index_i,
  input  way_t   unlock_way_i,
  input  logic   cnt_down_valid_i,
  input  id_t    cnt_down_id_i,
  output logic   init_done_o
);

  llc_tag_if tag_bus ();

  logic   lock_req;
  index_t lock_index;
  way_t   lock_way;
  logic   locked;
  logic   cnt_up;
  id_t    cnt_up_id;
  logic   to_miss;
  logic   stall;

  llc_hit_miss_ctrl i_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .desc_valid_i    (desc_valid_i),
    .desc_ready_o    (desc_ready_o),
    .desc_addr_i     (desc_addr_i),
    .desc_id_i       (desc_id_i),
    .desc_rw_i       (desc_rw_i),
    .hit_valid_o     (hit_valid_o),
    .hit_ready_i     (hit_ready_i),
    .miss_valid_o    (miss_valid_o),
    .miss_ready_i    (miss_ready_i),
    .out_addr_o      (out_addr_o),
    .out_id_o        (out_id_o),
    .out_rw_o        (out_rw_o),
    .out_way_o       (out_way_o),
    .out_refill_o    (out_refill_o),
    .out_evict_o     (out_evict_o),
    .out_evict_tag_o (out_evict_tag_o),
    .tag             (tag_bus),
    .init_done_i     (init_done_o),
    .lock_req_o      (lock_req),
    .lock_index_o    (lock_index),
    .lock_way_o      (lock_way),
    .locked_i        (locked),
    .cnt_up_o        (cnt_up),
    .cnt_up_id_o     (cnt_up_id),
    .to_miss_i       (to_miss),
    .stall_i         (stall)
  );

  llc_tag_store i_tag_store (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tag         (tag_bus),
    .init_done_o (init_done_o)
  );

  llc_lock_box i_lock_box (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lock_req_i     (lock_req),
    .lock_index_i   (lock_index),
    .lock_way_i     (lock_way),
    .locked_o       (locked),
    .unlock_valid_i (unlock_valid_i),
    .unlock_index_i (unlock_index_i),
    .unlock_way_i   (unlock_way_i)
  );

  // counter query uses the id of the descriptor in the unit
  llc_miss_counters i_miss_counters (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cnt_up_i      (cnt_up),
    .cnt_up_id_i   (cnt_up_id),
    .cnt_down_i    (cnt_down_valid_i),
    .cnt_down_id_i (cnt_down_id_i),
    .query_id_i    (cnt_up_id),
    .to_miss_o     (to_miss),
    .stall_o       (stall)
  );

endmodule

`default_nettype wire

// File: bench/llc_hit_miss_assertions.sv
`include "llc_defs.svh"

`timescale 1ns/1ps

`default_nettype none

// checker bound into the top level
// shadow of tags, dirty bits, locks and miss counters rebuilt from the output ports
module llc_hit_miss_assertions
  import llc_addr_pkg::*;
  import llc_desc_pkg::*;
(
  input logic   clk_i,
  input logic   reset_i,
  input logic   desc_valid_i,
  input logic   desc_ready_o,
  input addr_t  desc_addr_i,
  input id_t    desc_id_i,
  input logic   desc_rw_i,
  input logic   init_done_o,
  input logic   hit_valid_o,
  input logic   hit_ready_i,
  input logic   miss_valid_o,
  input logic   miss_ready_i,
  input addr_t  out_addr_o,
  input id_t    out_id_o,
  input logic   out_rw_o,
  input way_t   out_way_o,
  input logic   out_refill_o,
  input logic   out_evict_o,
  input tag_t   out_evict_tag_o,
  input logic   unlock_valid_i,
  input index_t unlock_index_i,
  input way_t   unlock_way_i,
  input logic   cnt_down_valid_i,
  input id_t    cnt_down_id_i
);

  localparam int unsigned SETS    = 1 << `LLC_INDEX_W;
  localparam int unsigned IDS     = 1 << `LLC_ID_W;
  localparam int unsigned CNT_MAX = (1 << `LLC_CNT_W) - 1;

  // failing assertions so far
  int unsigned fails = 0;

  tag_t        sh_tag   [SETS][`LLC_WAYS];
  way_t        sh_valid [SETS];
  way_t        sh_dirty [SETS];
  way_t        sh_lock  [SETS];
  int unsigned sh_cnt   [IDS];

  // descriptor in the unit, as accepted
  addr_t       pend_addr;
  id_t         pend_id;
  logic        pend_rw;

  index_t      o_set;
  tag_t        o_tag;
  int unsigned o_w;
  logic        any_match;
  logic        way_valid;
  logic        way_match;
  tag_t        exp_tag;
  logic        exp_evict;
  logic        locked;
  logic        cnt_zero;
  logic        out_xfer;
  desc_t       out_fields;

  ////////////////////////////////////////////////////////////
  // view of the outgoing descriptor against the shadow
  ////////////////////////////////////////////////////////////

  always_comb begin
    o_set     = out_addr_o[INDEX_BASE +: `LLC_INDEX_W];
    o_tag     = out_addr_o[TAG_BASE +: `LLC_TAG_W];
    o_w       = 0;
    any_match = 1'b0;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      if (out_way_o[w]) begin
        o_w = w;
      end
      // tag present anywhere in the set
      if (sh_valid[o_set][w] && sh_tag[o_set][w] == o_tag) begin
        any_match = 1'b1;
      end
    end
    way_valid  = sh_valid[o_set][o_w];
    way_match  = way_valid && (sh_tag[o_set][o_w] == o_tag);
    exp_tag    = sh_tag[o_set][o_w];
    // a valid victim is only picked when the set is full
    exp_evict  = way_valid && sh_dirty[o_set][o_w];
    locked     = |(sh_lock[o_set] & out_way_o);
    cnt_zero   = (sh_cnt[out_id_o] == 0);
    out_xfer   = (hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i);
    out_fields = {out_addr_o, out_id_o, out_rw_o, out_way_o, out_refill_o, out_evict_o,
                  out_evict_tag_o};
  end

  ////////////////////////////////////////////////////////////
  // shadow update on transfers and strobes
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < SETS; s++) begin
        sh_valid[s] <= '0;
        sh_dirty[s] <= '0;
        sh_lock[s]  <= '0;
      end
      for (int i = 0; i < IDS; i++) begin
        sh_cnt[i] <= 0;
      end
    end else begin
      if (desc_valid_i && desc_ready_o) begin
        pend_addr <= desc_addr_i;
        pend_id   <= desc_id_i;
        pend_rw   <= desc_rw_i;
      end
      if (unlock_valid_i) begin
        sh_lock[unlock_index_i] <= sh_lock[unlock_index_i] & ~unlock_way_i;
      end
      // later bit write wins, so a new lock beats an unlock
      if (out_xfer) begin
        sh_tag[o_set][o_w]   <= o_tag;
        sh_valid[o_set][o_w] <= 1'b1;
        sh_dirty[o_set][o_w] <= (!out_refill_o && sh_dirty[o_set][o_w]) || out_rw_o;
        sh_lock[o_set][o_w]  <= 1'b1;
      end
      for (int i = 0; i < IDS; i++) begin
        // miss-port transfer counts up, strobe counts down
        if (miss_valid_o && miss_ready_i && out_id_o == id_t'(i) &&
            !(cnt_down_valid_i && cnt_down_id_i == id_t'(i))) begin
          if (sh_cnt[i] != CNT_MAX) begin
            sh_cnt[i] <= sh_cnt[i] + 1;
          end
        end else if (cnt_down_valid_i && cnt_down_id_i == id_t'(i) &&
                     !(miss_valid_o && miss_ready_i && out_id_o == id_t'(i))) begin
          if (sh_cnt[i] != 0) begin
            sh_cnt[i] <= sh_cnt[i] - 1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  // nothing accepted while the array clears
  a_init: assert property (@(posedge clk_i) disable iff (reset_i)
    !init_done_o |-> !desc_ready_o)
    else begin
      fails++;
      $error("ERROR desc_ready_o %h while init_done_o %h",
             $sampled(desc_ready_o), $sampled(init_done_o));
    end

  a_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(hit_valid_o && miss_valid_o))
    else begin
      fails++;
      $error("ERROR hit_valid_o %h and miss_valid_o %h high together",
             $sampled(hit_valid_o), $sampled(miss_valid_o));
    end

  a_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_valid_o || miss_valid_o) |-> $onehot(out_way_o))
    else begin
      fails++;
      $error("ERROR out_way_o %h is not one-hot", $sampled(out_way_o));
    end

  // address, id and rw leave as they were accepted
  a_fields: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_valid_o || miss_valid_o) |->
      (out_addr_o == pend_addr && out_id_o == pend_id && out_rw_o == pend_rw))
    else begin
      fails++;
      $error("ERROR out_addr_o %h out_id_o %h out_rw_o %h expected %h %h %h",
             $sampled(out_addr_o), $sampled(out_id_o), $sampled(out_rw_o),
             $sampled(pend_addr), $sampled(pend_id), $sampled(pend_rw));
    end

  // stalled ports hold valid and fields
  a_hit_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_valid_o && !hit_ready_i) |=> (hit_valid_o && $stable(out_fields)))
    else begin
      fails++;
      $error("hit port dropped valid or changed its fields while stalled");
    end

  a_miss_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && !miss_ready_i) |=> (miss_valid_o && $stable(out_fields)))
    else begin
      fails++;
      $error("miss port dropped valid or changed its fields while stalled");
    end

  // a locked line never leaves
  a_lock: assert property (@(posedge clk_i) disable iff (reset_i)
    (hit_valid_o || miss_valid_o) |-> !locked)
    else begin
      fails++;
      $error("ERROR out_way_o %h leaves while its line is locked", $sampled(out_way_o));
    end

  // hit port only for a present tag and an id with no misses outstanding
  a_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    hit_valid_o |-> (way_match && cnt_zero && !out_refill_o && !out_evict_o))
    else begin
      fails++;
      $error("ERROR out_way_o %h tag %h refill %h on hit port, outstanding misses %h",
             $sampled(out_way_o), $sampled(o_tag), $sampled(out_refill_o),
             $sampled(!cnt_zero));
    end

  // pushed hit keeps its way and drops refill and evict
  a_pushed: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && !out_refill_o) |-> (way_match && !out_evict_o))
    else begin
      fails++;
      $error("ERROR out_way_o %h out_evict_o %h on pushed hit of tag %h",
             $sampled(out_way_o), $sampled(out_evict_o), $sampled(o_tag));
    end

  // a hit is only pushed when first offered behind an outstanding miss
  a_push_cause: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && !out_refill_o && !$past(miss_valid_o && !miss_ready_i)) |-> !cnt_zero)
    else begin
      fails++;
      $error("ERROR miss_valid_o %h for a hit of out_id_o %h with no outstanding miss",
             $sampled(miss_valid_o), $sampled(out_id_o));
    end

  a_refill: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && out_refill_o) |-> !any_match)
    else begin
      fails++;
      $error("ERROR out_refill_o %h for tag %h already present",
             $sampled(out_refill_o), $sampled(o_tag));
    end

  a_evict: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && out_refill_o) |-> (out_evict_o == exp_evict))
    else begin
      fails++;
      $error("ERROR out_evict_o %h expected %h", $sampled(out_evict_o), $sampled(exp_evict));
    end

  a_evict_tag: assert property (@(posedge clk_i) disable iff (reset_i)
    (miss_valid_o && out_evict_o) |-> (out_evict_tag_o == exp_tag))
    else begin
      fails++;
      $error("ERROR out_evict_tag_o %h expected %h",
             $sampled(out_evict_tag_o), $sampled(exp_tag));
    end

endmodule

bind llc_hit_miss llc_hit_miss_assertions checks (.*);

`default_nettype wire

// File: bench/tb_llc_hit_miss.sv
`timescale 1ns/1ps

`default_nettype none

module tb_llc_hit_miss
  import llc_addr_pkg::*;
  import llc_desc_pkg::*;
();

  localparam int unsigned SEED          = 47022;
  localparam int unsigned FIXED_OPS     = 20;
  localparam int unsigned RAND_OPS      = 60;
  // generous bound per access under random back-pressure
  localparam int unsigned CYCLES_PER_OP = 20;
  // plus reset and array clear
  localparam int unsigned CYCLE_LIMIT   = CYCLES_PER_OP * (FIXED_OPS + RAND_OPS) + 400;

  logic        clk_i;
  logic        reset_i;
  logic        desc_valid_i;
  logic        desc_ready_o;
  addr_t       desc_addr_i;
  id_t         desc_id_i;
  logic        desc_rw_i;
  logic        hit_valid_o;
  logic        hit_ready_i = 1'b1;
  logic        miss_valid_o;
  logic        miss_ready_i = 1'b1;
  addr_t       out_addr_o;
  id_t         out_id_o;
  logic        out_rw_o;
  way_t        out_way_o;
  logic        out_refill_o;
  logic        out_evict_o;
  tag_t        out_evict_tag_o;
  logic        unlock_valid_i;
  index_t      unlock_index_i;
  way_t        unlock_way_i;
  logic        cnt_down_valid_i;
  id_t         cnt_down_id_i;
  logic        init_done_o;

  logic        random_ready = 1'b0;
  int unsigned cycle_count = 0;
  int unsigned tb_fails = 0;
  int unsigned fails_at_start = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;

  llc_hit_miss uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // output readies, random only during the back-pressure test
  always @(negedge clk_i) begin
    if (random_ready) begin
      hit_ready_i  <= 1'($urandom);
      miss_ready_i <= 1'($urandom);
    end else begin
      hit_ready_i  <= 1'b1;
      miss_ready_i <= 1'b1;
    end
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned fail_total();
    return tb_fails + uut.checks.fails;
  endfunction

  // hold valid until the DUT takes the descriptor
  task automatic send_desc(input addr_t addr, input id_t id, input logic rw);
    @(negedge clk_i);
    desc_valid_i = 1'b1;
    desc_addr_i  = addr;
    desc_id_i    = id;
    desc_rw_i    = rw;
    do begin
      @(posedge clk_i);
    end while (!desc_ready_o);
    @(negedge clk_i);
    desc_valid_i = 1'b0;
  endtask

  // edges until a transfer on either port
  task automatic wait_output(output logic via_miss, output way_t way,
                             output int unsigned waited);
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i)));
    via_miss = miss_valid_o;
    way      = out_way_o;
  endtask

  task automatic access_line(input tag_t t, input index_t s, input id_t id, input logic rw,
                             output logic via_miss, output way_t way);
    int unsigned waited;
    send_desc(addr_t'({t, s, 4'h0}), id, rw);
    wait_output(via_miss, way, waited);
  endtask

  // one-cycle unlock and optional count-down strobes
  task automatic release_line(input index_t s, input way_t way, input logic down,
                              input id_t id);
    @(negedge clk_i);
    unlock_valid_i   = 1'b1;
    unlock_index_i   = s;
    unlock_way_i     = way;
    cnt_down_valid_i = down;
    cnt_down_id_i    = id;
    @(negedge clk_i);
    unlock_valid_i   = 1'b0;
    cnt_down_valid_i = 1'b0;
  endtask

  task automatic report_test(input string name);
    int unsigned n;
    n = fail_total() - fails_at_start;
    tests_run++;
    if (n == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d check(s) failed", tests_run, name, n);
    end
    fails_at_start = fail_total();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic        via_miss;
    way_t        way;
    way_t        way_b;
    int unsigned waited;
    tag_t        t;
    index_t      s;
    id_t         id;
    logic        rw;

    void'($urandom(SEED));
    reset_i          = 1'b1;
    desc_valid_i     = 1'b0;
    desc_addr_i      = '0;
    desc_id_i        = '0;
    desc_rw_i        = 1'b0;
    unlock_valid_i   = 1'b0;
    unlock_index_i   = '0;
    unlock_way_i     = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i    = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // valid raised during the clear, first access misses
    access_line(8'h11, 4'h1, 2'd0, 1'b0, via_miss, way);
    release_line(4'h1, way, via_miss, 2'd0);
    report_test("clear and first miss");

    access_line(8'h11, 4'h1, 2'd0, 1'b1, via_miss, way);
    release_line(4'h1, way, via_miss, 2'd0);
    access_line(8'h11, 4'h1, 2'd0, 1'b0, via_miss, way);
    release_line(4'h1, way, via_miss, 2'd0);
    report_test("repeated hit");

    // miss counted down, line left locked
    access_line(8'h22, 4'h2, 2'd1, 1'b0, via_miss, way_b);
    release_line(4'h2, '0, 1'b1, 2'd1);
    send_desc(addr_t'({8'h22, 4'h2, 4'h0}), 2'd1, 1'b0);
    repeat (5) @(posedge clk_i);
    release_line(4'h2, way_b, 1'b0, 2'd1);
    wait_output(via_miss, way, waited);
    assert (waited == 1) else begin
      tb_fails++;
      $error("locked descriptor needed %0d cycles to leave after its unlock", waited);
    end
    release_line(4'h2, way, via_miss, 2'd1);
    report_test("locked line");

    // id 2 keeps one miss outstanding, then hits line 4
    access_line(8'h33, 4'h3, 2'd2, 1'b0, via_miss, way);
    release_line(4'h3, way, 1'b0, 2'd2);
    access_line(8'h44, 4'h4, 2'd3, 1'b0, via_miss, way);
    release_line(4'h4, way, via_miss, 2'd3);
    access_line(8'h44, 4'h4, 2'd2, 1'b0, via_miss, way);
    release_line(4'h4, way, via_miss, 2'd2);
    release_line(4'h3, '0, 1'b1, 2'd2);
    report_test("hit behind outstanding miss");

    // five dirty tags into one four-way set
    for (int i = 0; i < 5; i++) begin
      access_line(tag_t'(8'h50 + i), 4'h5, 2'd0, 1'b1, via_miss, way);
      release_line(4'h5, way, via_miss, 2'd0);
    end
    report_test("dirty eviction");

    @(posedge clk_i);
    random_ready = 1'b1;
    for (int i = 0; i < RAND_OPS; i++) begin
      // draw the next access on the rising edge
      @(posedge clk_i);
      t  = tag_t'(8'h60 + $urandom % 6);
      s  = index_t'(8 + $urandom % 4);
      id = id_t'($urandom);
      rw = 1'($urandom);
      access_line(t, s, id, rw, via_miss, way);
      release_line(s, way, via_miss, id);
    end
    random_ready = 1'b0;
    report_test("random back-pressure");

    $display("tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0 && fail_total() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/llc_addr_pkg.sv
rtl/llc_desc_pkg.sv
rtl/llc_tag_if.sv
rtl/llc_hit_miss_ctrl.sv
rtl/llc_tag_store.sv
rtl/llc_lock_box.sv
rtl/llc_miss_counters.sv
rtl/llc_hit_miss.sv
bench/llc_hit_miss_assertions.sv
bench/tb_llc_hit_miss.sv

// File: run.sh
#!/bin/sh
# compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_llc_hit_miss -f build.f

# keep running after assertion errors so the testbench reports the result
out=$(./obj_dir/Vtb_llc_hit_miss +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All tests passed"
